// ==== build.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_stage_if.sv
hdl/rv_fetch.sv
hdl/rv_regs.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_write.sv
hdl/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_pkg.sv
      - hdl/rv_stage_if.sv
      - hdl/rv_fetch.sv
      - hdl/rv_regs.sv
      - hdl/rv_decode.sv
      - hdl/rv_execute.sv
      - hdl/rv_write.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/rv_core_checker.sv
      - verif/rv_core_tb.sv

// ==== verif/rv_core_tb.sv ====
`include "rv_config.svh"

module rv_core_tb;

    localparam int          NUM_TESTS     = 5;
    localparam int          PROG_LEN      = 8;
    localparam int          STORE_TIMEOUT = 500;
    localparam logic [6:0]  OP_IMM        = 7'b0010011;
    localparam logic [6:0]  LOAD          = 7'b0000011;
    localparam logic [31:0] READ_KEY      = 32'h5A5A_0000;

    logic                       clk;
    logic                       rst        = 1'b1;
    logic                       instr_req;
    logic [`RV_IADDR_BITS-1:0]  instr_addr;
    logic                       instr_ack  = 1'b0;
    logic [31:0]                instr_data = `RV_NOP;
    logic                       data_req;
    logic                       data_write;
    logic [`RV_XLEN-1:0]        data_addr;
    logic [`RV_XLEN-1:0]        data_wdata;
    logic                       data_ack   = 1'b0;
    logic [`RV_XLEN-1:0]        data_rdata = '0;

    string       test_name [NUM_TESTS];
    logic [31:0] prog_rom  [NUM_TESTS][PROG_LEN];
    logic [31:0] exp_addr  [NUM_TESTS];
    logic [31:0] exp_data  [NUM_TESTS];
    int          cur_test    = 0;
    integer      seed        = 58079;
    int          instr_wait  = -1;
    int          data_wait   = -1;
    int          check_count = 0;
    int          error_count = 0;

    rv_core u_dut (
        .i_clk          (clk),
        .i_rst          (rst),
        .o_instr_req    (instr_req),
        .o_instr_addr   (instr_addr),
        .i_instr_ack    (instr_ack),
        .i_instr_data   (instr_data),
        .o_data_req     (data_req),
        .o_data_write   (data_write),
        .o_data_addr    (data_addr),
        .o_data_wdata   (data_wdata),
        .i_data_ack     (data_ack),
        .i_data_rdata   (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        logic [31:0] v;
        v = imm;
        return {v[11:5], rs2[4:0], rs1[4:0], 3'b010, v[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        logic [31:0] v;
        v = imm;
        return {v[12], v[10:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd);
        logic [31:0] v;
        v = imm;
        return {v[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        logic [31:0] v;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], rd[4:0], 7'b1101111};
    endfunction

    // Words past the end of the program read as NOPs.
    function automatic logic [31:0] program_word(input logic [`RV_IADDR_BITS-1:0] addr);
        int idx;
        idx = addr >> 2;
        if (idx < PROG_LEN) begin
            return prog_rom[cur_test][idx];
        end
        return `RV_NOP;
    endfunction

    task automatic fill_table;
        for (int r = 0; r < NUM_TESTS; r++) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                prog_rom[r][i] = `RV_NOP;
            end
        end
        test_name[0]   = "alu_rr";
        prog_rom[0][0] = i_type(25, 0, 0, 1, OP_IMM);       // addi x1, x0, 25
        prog_rom[0][1] = i_type(-7, 0, 0, 2, OP_IMM);       // addi x2, x0, -7
        prog_rom[0][2] = r_type(7'h00, 2, 1, 0, 3);         // add  x3, x1, x2
        prog_rom[0][3] = r_type(7'h20, 2, 1, 0, 4);         // sub  x4, x1, x2
        prog_rom[0][4] = r_type(7'h00, 4, 3, 4, 5);         // xor  x5, x3, x4
        prog_rom[0][5] = r_type(7'h00, 1, 2, 2, 6);         // slt  x6, x2, x1
        prog_rom[0][6] = r_type(7'h00, 6, 5, 0, 7);         // add  x7, x5, x6
        prog_rom[0][7] = s_type(64, 7, 0);                  // sw   x7, 64(x0)
        exp_addr[0]    = 32'h0000_0040;
        exp_data[0]    = 32'h0000_0033;
        test_name[1]   = "lui_shift";
        prog_rom[1][0] = u_type('h87654, 1);                // lui  x1, 0x87654
        prog_rom[1][1] = i_type('h321, 1, 0, 1, OP_IMM);    // addi x1, x1, 0x321
        prog_rom[1][2] = i_type('h408, 1, 5, 2, OP_IMM);    // srai x2, x1, 8
        prog_rom[1][3] = i_type(12, 1, 5, 3, OP_IMM);       // srli x3, x1, 12
        prog_rom[1][4] = i_type(8, 3, 1, 4, OP_IMM);        // slli x4, x3, 8
        prog_rom[1][5] = r_type(7'h00, 2, 4, 3, 5);         // sltu x5, x4, x2
        prog_rom[1][6] = r_type(7'h00, 5, 4, 0, 6);         // add  x6, x4, x5
        prog_rom[1][7] = s_type(68, 6, 0);                  // sw   x6, 68(x0)
        exp_addr[1]    = 32'h0000_0044;
        exp_data[1]    = 32'h0876_5401;
        test_name[2]   = "forward_chain";
        prog_rom[2][0] = i_type(3, 0, 0, 1, OP_IMM);        // addi x1, x0, 3
        prog_rom[2][1] = r_type(7'h00, 1, 1, 0, 2);         // add  x2, x1, x1
        prog_rom[2][2] = r_type(7'h00, 1, 2, 0, 3);         // add  x3, x2, x1
        prog_rom[2][3] = r_type(7'h20, 2, 3, 0, 4);         // sub  x4, x3, x2
        prog_rom[2][4] = r_type(7'h00, 4, 3, 1, 5);         // sll  x5, x3, x4
        prog_rom[2][5] = r_type(7'h00, 2, 5, 6, 6);         // or   x6, x5, x2
        prog_rom[2][6] = i_type(2, 6, 0, 7, OP_IMM);        // addi x7, x6, 2
        prog_rom[2][7] = s_type(16, 6, 7);                  // sw   x6, 16(x7)
        exp_addr[2]    = 32'h0000_0060;
        exp_data[2]    = 32'h0000_004E;
        test_name[3]   = "load_use";
        prog_rom[3][0] = i_type(256, 0, 0, 1, OP_IMM);      // addi x1, x0, 256
        prog_rom[3][1] = i_type(8, 1, 2, 2, LOAD);          // lw   x2, 8(x1)
        prog_rom[3][2] = i_type(1, 2, 0, 3, OP_IMM);        // addi x3, x2, 1
        prog_rom[3][3] = i_type(32, 0, 2, 4, LOAD);         // lw   x4, 32(x0)
        prog_rom[3][4] = r_type(7'h00, 3, 4, 4, 5);         // xor  x5, x4, x3
        prog_rom[3][5] = s_type(64, 5, 1);                  // sw   x5, 64(x1)
        exp_addr[3]    = 32'h0000_0140;
        exp_data[3]    = 32'h0000_0129;
        test_name[4]   = "branch_jal";
        prog_rom[4][0] = i_type(64, 0, 0, 1, OP_IMM);       // addi x1, x0, 64
        prog_rom[4][1] = i_type(64, 0, 0, 2, OP_IMM);       // addi x2, x0, 64
        prog_rom[4][2] = b_type(8, 2, 1, 0);                // beq  x1, x2, +8
        prog_rom[4][3] = i_type(4, 1, 0, 1, OP_IMM);        // addi x1, x1, 4
        prog_rom[4][4] = b_type(8, 2, 1, 1);                // bne  x1, x2, +8
        prog_rom[4][5] = j_type(8, 3);                      // jal  x3, +8
        prog_rom[4][6] = i_type(0, 0, 0, 3, OP_IMM);        // addi x3, x0, 0
        prog_rom[4][7] = s_type(0, 3, 1);                   // sw   x3, 0(x1)
        exp_addr[4]    = 32'h0000_0040;
        exp_data[4]    = 32'h0000_0018;
    endtask

    // Instruction and data memories. Each request is acknowledged after 0 to 3 cycles.
    // Data reads return the address XOR a fixed key.
    always @(negedge clk) begin
        if (rst) begin
            instr_ack  = 1'b0;
            instr_wait = -1;
            data_ack   = 1'b0;
            data_wait  = -1;
        end else begin
            instr_ack = 1'b0;
            if (instr_req) begin
                if (instr_wait < 0) begin
                    instr_wait = {$random(seed)} % 4;
                end
                if (instr_wait == 0) begin
                    instr_ack  = 1'b1;
                    instr_data = program_word(instr_addr);
                    instr_wait = -1;
                end else begin
                    instr_wait = instr_wait - 1;
                end
            end
            data_ack = 1'b0;
            if (data_req) begin
                if (data_wait < 0) begin
                    data_wait = {$random(seed)} % 4;
                end
                if (data_wait == 0) begin
                    data_ack   = 1'b1;
                    data_rdata = data_addr ^ READ_KEY;
                    data_wait  = -1;
                end else begin
                    data_wait = data_wait - 1;
                end
            end
        end
    end

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %08h, actual %08h", name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic apply_reset;
        rst <= 1'b1;
        repeat (10) begin
            @(posedge clk);
            @(negedge clk);
            check_count++;
            if (instr_req !== 1'b0 || data_req !== 1'b0) begin
                $display("ERROR: bus request active during reset (instr_req=%b, data_req=%b)",
                         instr_req, data_req);
                error_count++;
            end
        end
        rst <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int   cyc;
        logic found;
        apply_reset();
        // The first fetch is issued in the first cycle after reset.
        @(negedge clk);
        check_count++;
        if (instr_req !== 1'b1) begin
            $display("ERROR: %s: no instruction request in the first cycle after reset",
                     test_name[t]);
            error_count++;
        end else begin
            check_value(test_name[t], "first fetch address", `RV_RESET_ADDR, instr_addr);
        end
        found = 1'b0;
        cyc   = 0;
        while (!found && cyc < STORE_TIMEOUT) begin
            @(negedge clk);
            found = data_req && data_write;
            cyc++;
        end
        if (!found) begin
            $display("ERROR: %s: no store appeared within %0d cycles", test_name[t],
                     STORE_TIMEOUT);
            error_count++;
        end else begin
            check_value(test_name[t], "store address", exp_addr[t], data_addr);
            check_value(test_name[t], "store data", exp_data[t], data_wdata);
        end
    endtask

    initial begin
        fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = t;
            run_test(t);
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verif/rv_core_checker.sv ====
`include "rv_config.svh"

module rv_core_checker (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_instr_req,
    input  logic [`RV_IADDR_BITS-1:0]   i_instr_addr,
    input  logic                        i_instr_ack,
    input  logic                        i_data_req,
    input  logic                        i_data_write,
    input  logic [`RV_XLEN-1:0]         i_data_addr,
    input  logic [`RV_XLEN-1:0]         i_data_wdata,
    input  logic                        i_data_ack
);

    // An instruction request holds its address until it is acknowledged.
    instr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_instr_req && !i_instr_ack |=> i_instr_req && $stable(i_instr_addr))
        else $error("instruction request dropped or changed before ack");

    data_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_data_req && !i_data_ack |=> i_data_req && $stable(i_data_write) &&
        $stable(i_data_addr) && $stable(i_data_wdata))
        else $error("data request dropped or changed before ack");

    // The first reset edge clears the pipeline, so the check starts one cycle later.
    data_idle_in_reset: assert property (@(posedge i_clk)
        i_rst && $past(i_rst) |-> !i_data_req)
        else $error("data request active during reset");

    instr_idle_in_reset: assert property (@(posedge i_clk)
        i_rst && $past(i_rst) |-> !i_instr_req)
        else $error("instruction request active during reset");

    data_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_data_req |-> i_data_addr[1:0] == 2'b00)
        else $error("data address not word aligned");

endmodule

bind rv_core rv_core_checker u_checker (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_instr_req    (o_instr_req),
    .i_instr_addr   (o_instr_addr),
    .i_instr_ack    (i_instr_ack),
    .i_data_req     (o_data_req),
    .i_data_write   (o_data_write),
    .i_data_addr    (o_data_addr),
    .i_data_wdata   (o_data_wdata),
    .i_data_ack     (i_data_ack)
);

// ==== hdl/rv_core.sv ====
`include "rv_config.svh"

module rv_core (
    input  logic                        i_clk,
    input  logic                        i_rst,
    output logic                        o_instr_req,
    output logic [`RV_IADDR_BITS-1:0]   o_instr_addr,
    input  logic                        i_instr_ack,
    input  logic [31:0]                 i_instr_data,
    output logic                        o_data_req,
    output logic                        o_data_write,
    output logic [`RV_XLEN-1:0]         o_data_addr,
    output logic [`RV_XLEN-1:0]         o_data_wdata,
    input  logic                        i_data_ack,
    input  logic [`RV_XLEN-1:0]         i_data_rdata
);

    rv_fetch_if f_link ();
    rv_exec_if  e_link ();

    rv_pkg::decode_t             dec;
    logic [`RV_XLEN-1:0]         rs1_data;
    logic [`RV_XLEN-1:0]         rs2_data;
    logic                        hold;
    logic                        redirect;
    logic [`RV_IADDR_BITS-1:0]   target;
    logic                        wb_we;
    logic [`RV_REG_BITS-1:0]     wb_rd;
    logic [`RV_XLEN-1:0]         wb_data;

    rv_fetch u_fetch (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_redirect     (redirect),
        .i_target       (target),
        .i_instr_ack    (i_instr_ack),
        .i_instr_data   (i_instr_data),
        .o_instr_req    (o_instr_req),
        .o_instr_addr   (o_instr_addr),
        .f_if           (f_link.fetch)
    );

    rv_decode u_decode (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_redirect     (redirect),
        .i_hold         (hold),
        .f_if           (f_link.decode),
        .i_wb_we        (wb_we),
        .i_wb_rd        (wb_rd),
        .i_wb_data      (wb_data),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data),
        .o_dec          (dec)
    );

    rv_execute u_execute (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_dec          (dec),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_wb_we        (wb_we),
        .i_wb_rd        (wb_rd),
        .i_wb_data      (wb_data),
        .o_hold         (hold),
        .o_redirect     (redirect),
        .o_target       (target),
        .e_if           (e_link.exec)
    );

    rv_write u_write (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .w_if           (e_link.write),
        .o_data_req     (o_data_req),
        .o_data_write   (o_data_write),
        .o_data_addr    (o_data_addr),
        .o_data_wdata   (o_data_wdata),
        .i_data_ack     (i_data_ack),
        .i_data_rdata   (i_data_rdata),
        .o_wb_we        (wb_we),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data)
    );

endmodule

// ==== hdl/rv_write.sv ====
`include "rv_config.svh"

module rv_write (
    input  logic                        i_clk,
    input  logic                        i_rst,
    rv_exec_if.write                    w_if,
    output logic                        o_data_req,
    output logic                        o_data_write,
    output logic [`RV_XLEN-1:0]         o_data_addr,
    output logic [`RV_XLEN-1:0]         o_data_wdata,
    input  logic                        i_data_ack,
    input  logic [`RV_XLEN-1:0]         i_data_rdata,
    output logic                        o_wb_we,
    output logic [`RV_REG_BITS-1:0]     o_wb_rd,
    output logic [`RV_XLEN-1:0]         o_wb_data
);

    logic mem_op;

    assign mem_op = w_if.valid && (w_if.res_src == rv_pkg::RES_MEM);

    // Loads write a register and stores do not.
    assign o_data_req   = mem_op;
    assign o_data_write = !w_if.reg_write;
    assign o_data_addr  = w_if.result;
    assign o_data_wdata = w_if.store_data;

    assign w_if.busy = mem_op && !i_data_ack;

    assign o_wb_we   = w_if.valid && w_if.reg_write && !w_if.busy;
    assign o_wb_rd   = w_if.rd;
    assign o_wb_data = (w_if.res_src == rv_pkg::RES_MEM) ? i_data_rdata : w_if.result;

endmodule

// ==== hdl/rv_execute.sv ====
`include "rv_config.svh"

module rv_execute (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  rv_pkg::decode_t             i_dec,
    input  logic [`RV_XLEN-1:0]         i_rs1_data,
    input  logic [`RV_XLEN-1:0]         i_rs2_data,
    input  logic                        i_wb_we,
    input  logic [`RV_REG_BITS-1:0]     i_wb_rd,
    input  logic [`RV_XLEN-1:0]         i_wb_data,
    output logic                        o_hold,
    output logic                        o_redirect,
    output logic [`RV_IADDR_BITS-1:0]   o_target,
    rv_exec_if.exec                     e_if
);

    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] rs2v;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] alu;
    logic [`RV_XLEN-1:0] pc4;
    logic [4:0]          shamt;
    logic                taken;

    // Results from the write stage override the values read in decode.
    assign op1  = (i_wb_we && i_wb_rd != '0 && i_wb_rd == i_dec.rs1) ? i_wb_data : i_rs1_data;
    assign rs2v = (i_wb_we && i_wb_rd != '0 && i_wb_rd == i_dec.rs2) ? i_wb_data : i_rs2_data;
    assign op2  = i_dec.op2_imm ? i_dec.imm : rs2v;
    assign shamt = op2[4:0];

    always_comb begin
        case (i_dec.alu_op)
            rv_pkg::ALU_SUB:  alu = op1 - op2;
            rv_pkg::ALU_AND:  alu = op1 & op2;
            rv_pkg::ALU_OR:   alu = op1 | op2;
            rv_pkg::ALU_XOR:  alu = op1 ^ op2;
            rv_pkg::ALU_SLT:  alu = `RV_XLEN'($signed(op1) < $signed(op2));
            rv_pkg::ALU_SLTU: alu = `RV_XLEN'(op1 < op2);
            rv_pkg::ALU_SLL:  alu = op1 << shamt;
            rv_pkg::ALU_SRL:  alu = op1 >> shamt;
            rv_pkg::ALU_SRA:  alu = $signed(op1) >>> shamt;
            default:          alu = op1 + op2;
        endcase
    end

    assign pc4   = `RV_XLEN'(i_dec.pc) + `RV_XLEN'(4);
    assign taken = i_dec.is_jal || (i_dec.is_branch && ((op1 == rs2v) != i_dec.branch_ne));

    assign o_hold     = e_if.busy;
    assign o_redirect = i_dec.valid && taken && !e_if.busy;
    assign o_target   = i_dec.pc + i_dec.imm[`RV_IADDR_BITS-1:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            e_if.valid <= 1'b0;
        end else if (!e_if.busy) begin
            e_if.valid      <= i_dec.valid && (i_dec.reg_write || i_dec.is_store);
            e_if.rd         <= i_dec.rd;
            e_if.reg_write  <= i_dec.reg_write;
            e_if.res_src    <= i_dec.res_src;
            e_if.result     <= (i_dec.res_src == rv_pkg::RES_PC4) ? pc4 : alu;
            e_if.store_data <= rs2v;
        end
    end

endmodule

// ==== hdl/rv_decode.sv ====
`include "rv_config.svh"

module rv_decode (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_redirect,
    input  logic                        i_hold,
    rv_fetch_if.decode                  f_if,
    input  logic                        i_wb_we,
    input  logic [`RV_REG_BITS-1:0]     i_wb_rd,
    input  logic [`RV_XLEN-1:0]         i_wb_data,
    output logic [`RV_XLEN-1:0]         o_rs1_data,
    output logic [`RV_XLEN-1:0]         o_rs2_data,
    output rv_pkg::decode_t             o_dec
);

    rv_pkg::decode_t         dec;
    logic [31:0]             ins;
    logic                    f7;
    logic                    hazard;
    logic                    take;
    logic [`RV_REG_BITS-1:0] rd_idx1;
    logic [`RV_REG_BITS-1:0] rd_idx2;
    logic [`RV_XLEN-1:0]     rd1;
    logic [`RV_XLEN-1:0]     rd2;

    assign ins = f_if.instr;
    assign f7  = ins[30];

    always_comb begin
        dec           = '0;
        dec.valid     = 1'b1;
        dec.pc        = f_if.pc;
        dec.rd        = ins[11:7];
        dec.alu_op    = rv_pkg::ALU_ADD;
        dec.res_src   = rv_pkg::RES_ALU;
        dec.imm       = {{20{ins[31]}}, ins[31:20]};
        case (ins[6:0])
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                dec.rs1       = ins[19:15];
                dec.op2_imm   = (ins[6:0] == rv_pkg::OPC_OP_IMM);
                dec.rs2       = dec.op2_imm ? '0 : ins[24:20];
                dec.reg_write = 1'b1;
                case (ins[14:12])
                    3'd0: dec.alu_op = (f7 && !dec.op2_imm) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'd1: dec.alu_op = rv_pkg::ALU_SLL;
                    3'd2: dec.alu_op = rv_pkg::ALU_SLT;
                    3'd3: dec.alu_op = rv_pkg::ALU_SLTU;
                    3'd4: dec.alu_op = rv_pkg::ALU_XOR;
                    3'd5: dec.alu_op = f7 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'd6: dec.alu_op = rv_pkg::ALU_OR;
                    default: dec.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                dec.imm       = {ins[31:12], 12'b0};
                dec.op2_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                dec.rs1       = ins[19:15];
                dec.op2_imm   = 1'b1;
                dec.res_src   = rv_pkg::RES_MEM;
                dec.reg_write = (ins[14:12] == 3'd2);
            end
            rv_pkg::OPC_STORE: begin
                dec.rs1      = ins[19:15];
                dec.rs2      = ins[24:20];
                dec.imm      = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                dec.op2_imm  = 1'b1;
                dec.res_src  = rv_pkg::RES_MEM;
                dec.is_store = (ins[14:12] == 3'd2);
            end
            rv_pkg::OPC_BRANCH: begin
                dec.rs1       = ins[19:15];
                dec.rs2       = ins[24:20];
                dec.imm       = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                dec.is_branch = (ins[14:13] == 2'b00);
                dec.branch_ne = ins[12];
            end
            rv_pkg::OPC_JAL: begin
                dec.imm       = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                dec.res_src   = rv_pkg::RES_PC4;
                dec.reg_write = 1'b1;
                dec.is_jal    = 1'b1;
            end
            default: ;
        endcase
    end

    // A load still in execute cannot feed the next instruction yet.
    assign hazard = o_dec.valid && o_dec.res_src == rv_pkg::RES_MEM && o_dec.reg_write &&
                    o_dec.rd != '0 && (o_dec.rd == dec.rs1 || o_dec.rd == dec.rs2);
    assign f_if.stall = i_hold || hazard;
    assign take       = f_if.valid && !f_if.stall;

    // While held, the register data is read again so that write-backs are not missed.
    assign rd_idx1 = i_hold ? o_dec.rs1 : dec.rs1;
    assign rd_idx2 = i_hold ? o_dec.rs2 : dec.rs2;

    rv_regs u_regs (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_rs1  (rd_idx1),
        .i_rs2  (rd_idx2),
        .i_we   (i_wb_we),
        .i_rd   (i_wb_rd),
        .i_wd   (i_wb_data),
        .o_rd1  (rd1),
        .o_rd2  (rd2)
    );

    always_ff @(posedge i_clk) begin
        o_rs1_data <= rd1;
        o_rs2_data <= rd2;
        if (i_rst || i_redirect) begin
            o_dec.valid <= 1'b0;
        end else if (!i_hold) begin
            if (take) begin
                o_dec <= dec;
            end else begin
                o_dec.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/rv_regs.sv ====
`include "rv_config.svh"

module rv_regs (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic [`RV_REG_BITS-1:0]     i_rs1,
    input  logic [`RV_REG_BITS-1:0]     i_rs2,
    input  logic                        i_we,
    input  logic [`RV_REG_BITS-1:0]     i_rd,
    input  logic [`RV_XLEN-1:0]         i_wd,
    output logic [`RV_XLEN-1:0]         o_rd1,
    output logic [`RV_XLEN-1:0]         o_rd2
);

    logic [`RV_XLEN-1:0] regs [2**`RV_REG_BITS];
    logic                wr_en;

    assign wr_en = i_we && !i_rst && (i_rd != '0);

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            regs[i_rd] <= i_wd;
        end
    end

    // A write in the same cycle is visible to the reads.
    assign o_rd1 = (i_rs1 == '0) ? '0 : (wr_en && i_rd == i_rs1) ? i_wd : regs[i_rs1];
    assign o_rd2 = (i_rs2 == '0) ? '0 : (wr_en && i_rd == i_rs2) ? i_wd : regs[i_rs2];

endmodule

// ==== hdl/rv_fetch.sv ====
`include "rv_config.svh"

module rv_fetch (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_redirect,
    input  logic [`RV_IADDR_BITS-1:0]   i_target,
    input  logic                        i_instr_ack,
    input  logic [31:0]                 i_instr_data,
    output logic                        o_instr_req,
    output logic [`RV_IADDR_BITS-1:0]   o_instr_addr,
    rv_fetch_if.fetch                   f_if
);

    logic [`RV_IADDR_BITS-1:0] pc;
    logic [`RV_IADDR_BITS-1:0] pc_sel;
    logic                      req;
    logic                      discard;
    logic                      done;
    logic                      fill;
    logic                      buf_free;

    assign done     = req && i_instr_ack;
    assign fill     = done && !discard && !i_redirect;
    assign buf_free = !f_if.valid || !f_if.stall || i_redirect;
    assign pc_sel   = i_redirect ? i_target : pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            req        <= 1'b0;
            discard    <= 1'b0;
            f_if.valid <= 1'b0;
            pc         <= `RV_RESET_ADDR;
        end else begin
            if (f_if.valid && !f_if.stall) begin
                f_if.valid <= 1'b0;
            end
            if (done) begin
                req     <= 1'b0;
                discard <= 1'b0;
            end
            if (fill) begin
                f_if.valid <= 1'b1;
                f_if.instr <= i_instr_data;
                f_if.pc    <= o_instr_addr;
            end
            // The response still on its way belongs to the old path.
            if (i_redirect) begin
                f_if.valid <= 1'b0;
                pc         <= i_target;
                if (req && !i_instr_ack) begin
                    discard <= 1'b1;
                end
            end
            if ((!req || done) && buf_free && !fill) begin
                req          <= 1'b1;
                o_instr_addr <= pc_sel;
                pc           <= pc_sel + `RV_IADDR_BITS'd4;
            end
        end
    end

    assign o_instr_req = req;

endmodule

// ==== hdl/rv_stage_if.sv ====
`include "rv_config.svh"

interface rv_fetch_if;
    logic                       valid;
    logic [31:0]                instr;
    logic [`RV_IADDR_BITS-1:0]  pc;
    logic                       stall;

    modport fetch (output valid, output instr, output pc, input stall);
    modport decode (input valid, input instr, input pc, output stall);
endinterface

interface rv_exec_if;
    logic                       valid;
    logic [`RV_REG_BITS-1:0]    rd;
    logic                       reg_write;
    rv_pkg::res_src_e           res_src;
    logic [`RV_XLEN-1:0]        result;
    logic [`RV_XLEN-1:0]        store_data;
    logic                       busy;

    modport exec (
        output valid, output rd, output reg_write, output res_src,
        output result, output store_data, input busy
    );
    modport write (
        input valid, input rd, input reg_write, input res_src,
        input result, input store_data, output busy
    );
endinterface

// ==== hdl/rv_pkg.sv ====
`include "rv_config.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    // Selects what the write stage puts into the register file.
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } res_src_e;

    typedef struct packed {
        logic                       valid;
        logic [`RV_IADDR_BITS-1:0]  pc;
        logic [`RV_REG_BITS-1:0]    rs1;
        logic [`RV_REG_BITS-1:0]    rs2;
        logic [`RV_REG_BITS-1:0]    rd;
        logic [`RV_XLEN-1:0]        imm;
        alu_op_e                    alu_op;
        res_src_e                   res_src;
        logic                       reg_write;
        logic                       op2_imm;
        logic                       is_store;
        logic                       is_branch;
        logic                       branch_ne;
        logic                       is_jal;
    } decode_t;

endpackage

// ==== hdl/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Integer register width.
`define RV_XLEN 32

// Register index width, which gives 32 registers.
`define RV_REG_BITS 5

// Byte address width of the instruction bus.
`define RV_IADDR_BITS 16

// First address fetched after reset.
`define RV_RESET_ADDR 16'h0000

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif
